/* src.f */
div_pkg.sv
div_lane.sv
div_operand_prep.sv
div_result_pack.sv
div_unit.sv
tb_clk_gen.sv
tb_div_unit.sv

/* Bender.yml */
package:
  name: div_unit

sources:
  - files:
      - div_pkg.sv
      - div_lane.sv
      - div_operand_prep.sv
      - div_result_pack.sv
      - div_unit.sv
  - target: simulation
    files:
      - tb_clk_gen.sv
      - tb_div_unit.sv

/* tb_div_unit.sv */
`timescale 1ns/1ns

module tb_div_unit import div_pkg::*; ();

  localparam int VLEN    = 128;
  localparam int TIMEOUT = 200;

  logic            clk;
  logic            rst_n;
  logic            uop_valid;
  div_ctrl_t       uop_ctrl;
  logic [VLEN-1:0] vs1_data;
  logic [VLEN-1:0] vs2_data;
  xreg_t           rs1_data;
  logic            result_ready;
  logic            result_valid;
  rob_tag_t        result_tag;
  logic [VLEN-1:0] result_data;

  logic [31:0]     lfsr;
  logic [VLEN-1:0] exp_data;
  rob_tag_t        exp_tag;
  rob_tag_t        next_tag;
  logic            in_flight;
  logic            timed_out;
  int              errors;
  int              tests_run;
  int              tests_failed;

  tb_clk_gen #(.PERIOD(8), .RST_CYCLES(3)) u_clk (.clk(clk), .rst_n(rst_n));

  div_unit #(.VLEN(VLEN)) uut (
    .clk          (clk),
    .rst_n        (rst_n),
    .uop_valid    (uop_valid),
    .uop_ctrl     (uop_ctrl),
    .vs1_data     (vs1_data),
    .vs2_data     (vs2_data),
    .rs1_data     (rs1_data),
    .result_ready (result_ready),
    .result_valid (result_valid),
    .result_tag   (result_tag),
    .result_data  (result_data)
  );

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task automatic rand_bits(input int n, output logic [VLEN-1:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      v[i] = lfsr[0];
      lfsr = lfsr_next(lfsr);
    end
  endtask

  function automatic eew_e eew_of(input int w);
    case (w)
      8:       return EEW8;
      16:      return EEW16;
      default: return EEW32;
    endcase
  endfunction

  // one element under the RISC-V divide rules
  function automatic logic [31:0] divide_element(input logic [31:0] a, input logic [31:0] b,
                                                 input int w, input div_op_e op);
    longint      sa;
    longint      sb;
    longint      q;
    longint      r;
    logic        sgn;
    logic [31:0] mask;
    mask = (w == 32) ? 32'hffff_ffff : ((32'd1 << w) - 1);
    sgn  = (op == OP_DIV) || (op == OP_REM);
    sa   = longint'(a & mask);
    sb   = longint'(b & mask);
    if (sgn && a[w-1]) sa = sa - (longint'(1) << w);
    if (sgn && b[w-1]) sb = sb - (longint'(1) << w);
    if (sb == 0) begin
      q = -1;
      r = sa;
    end else if (sgn && sa == -(longint'(1) << (w - 1)) && sb == -1) begin
      q = sa;
      r = 0;
    end else begin
      q = sa / sb;
      r = sa % sb;
    end
    return ((op == OP_DIVU || op == OP_DIV) ? q[31:0] : r[31:0]) & mask;
  endfunction

  function automatic logic [VLEN-1:0] expected_vector(input logic [VLEN-1:0] vs1,
      input logic [VLEN-1:0] vs2, input xreg_t rs1, input div_op_e op,
      input src_sel_e src, input int w);
    logic [VLEN-1:0] res;
    logic [VLEN-1:0] elem;
    logic [31:0]     a;
    logic [31:0]     b;
    res = '0;
    for (int e = 0; e < VLEN / w; e++) begin
      a    = 32'(vs2 >> (e * w));
      b    = (src == SRC_VX) ? rs1 : 32'(vs1 >> (e * w));
      elem = '0;
      elem[31:0] = divide_element(a, b, w, op);
      res  = res | (elem << (e * w));
    end
    return res;
  endfunction

  // small divisors of either sign keep the quotients away from 0 and 1
  task automatic make_operands(input int w, output logic [VLEN-1:0] vs1,
                               output logic [VLEN-1:0] vs2);
    logic [VLEN-1:0] b;
    logic [VLEN-1:0] s;
    logic [VLEN-1:0] m;
    rand_bits(VLEN, vs2);
    m   = {VLEN{1'b1}} >> (VLEN - w);
    vs1 = '0;
    for (int e = 0; e < VLEN / w; e++) begin
      rand_bits(w / 2, b);
      rand_bits(1, s);
      if (s[0]) b = -b;
      vs1 = vs1 | ((b & m) << (e * w));
    end
  endtask

  task automatic issue_uop(input div_op_e op, input src_sel_e src, input int w,
                           input logic [VLEN-1:0] vs1, input logic [VLEN-1:0] vs2,
                           input xreg_t rs1, input int hold);
    int cycles;
    if (timed_out) return;
    exp_data         = expected_vector(vs1, vs2, rs1, op, src, w);
    exp_tag          = next_tag;
    next_tag         = next_tag + 1'b1;
    uop_ctrl.tag     = exp_tag;
    uop_ctrl.op      = op;
    uop_ctrl.src_sel = src;
    uop_ctrl.eew     = eew_of(w);
    vs1_data         = vs1;
    vs2_data         = vs2;
    rs1_data         = rs1;
    in_flight        = 1'b1;
    uop_valid        = 1'b1;
    @(negedge clk);
    uop_valid = 1'b0;
    cycles = 0;
    while (!result_valid && cycles < TIMEOUT) begin
      @(negedge clk);
      cycles++;
    end
    if (!result_valid) begin
      $display("timeout: no result for tag %0d after %0d cycles", exp_tag, cycles);
      timed_out = 1'b1;
      return;
    end
    for (int i = 0; i < hold; i++) begin
      @(negedge clk);
      assert (result_valid === 1'b1) else begin
        $display("CHECK FAILED at %0t: result_valid got %b expected 1",
                 $time, result_valid);
        errors++;
      end
      assert (result_data === exp_data) else begin
        $display("CHECK FAILED at %0t: result_data got %h expected %h",
                 $time, result_data, exp_data);
        errors++;
      end
      assert (result_tag === exp_tag) else begin
        $display("CHECK FAILED at %0t: result_tag got %0d expected %0d",
                 $time, result_tag, exp_tag);
        errors++;
      end
    end
    result_ready = 1'b1;
    @(negedge clk);
    result_ready = 1'b0;
    in_flight    = 1'b0;
  endtask

  task automatic end_test(input string name, input int errors_before);
    tests_run++;
    if (errors != errors_before || timed_out) begin
      tests_failed++;
      $display("test %s: failed, %0d new errors", name, errors - errors_before);
    end else begin
      $display("test %s: ok", name);
    end
  endtask

  // sampled on the rising edge while stimulus moves on the falling one
  always @(posedge clk) begin
    if (rst_n) begin
      if (!in_flight) begin
        assert (result_valid === 1'b0) else begin
          $display("CHECK FAILED at %0t: result_valid got %b expected 0",
                   $time, result_valid);
          errors++;
        end
      end else if (result_valid) begin
        assert (result_data === exp_data) else begin
          $display("CHECK FAILED at %0t: result_data got %h expected %h",
                   $time, result_data, exp_data);
          errors++;
        end
        assert (result_tag === exp_tag) else begin
          $display("CHECK FAILED at %0t: result_tag got %0d expected %0d",
                   $time, result_tag, exp_tag);
          errors++;
        end
      end
    end
  end

  initial begin
    int              cycles;
    int              start_errs;
    int              w;
    logic [VLEN-1:0] a_vec;
    logic [VLEN-1:0] b_vec;
    logic [VLEN-1:0] tmp;
    lfsr         = 32'd10;
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    uop_valid    = 1'b0;
    uop_ctrl     = '0;
    vs1_data     = '0;
    vs2_data     = '0;
    rs1_data     = '0;
    result_ready = 1'b0;
    in_flight    = 1'b0;
    timed_out    = 1'b0;
    next_tag     = '0;
    exp_data     = '0;
    exp_tag      = '0;

    cycles = 0;
    while (rst_n !== 1'b1 && cycles < TIMEOUT) begin
      @(negedge clk);
      cycles++;
    end
    if (rst_n !== 1'b1) begin
      $display("timeout: reset was never released");
      timed_out = 1'b1;
    end

    start_errs = errors;
    repeat (4) @(negedge clk);
    assert (result_valid === 1'b0) else begin
      $display("CHECK FAILED at %0t: result_valid got %b expected 0",
               $time, result_valid);
      errors++;
    end
    end_test("idle after reset", start_errs);

    start_errs = errors;
    for (int k = 0; k < 3; k++) begin
      w = 8 << k;
      make_operands(w, a_vec, b_vec);
      issue_uop(OP_DIVU, SRC_VV, w, a_vec, b_vec, '0, 0);
      issue_uop(OP_REMU, SRC_VV, w, a_vec, b_vec, '0, 0);
    end
    end_test("vv unsigned", start_errs);

    start_errs = errors;
    for (int k = 0; k < 3; k++) begin
      w = 8 << k;
      make_operands(w, a_vec, b_vec);
      issue_uop(OP_DIV, SRC_VV, w, a_vec, b_vec, '0, 0);
      issue_uop(OP_REM, SRC_VV, w, a_vec, b_vec, '0, 0);
    end
    end_test("vv signed", start_errs);

    start_errs = errors;
    for (int k = 0; k < 3; k++) begin
      w = 8 << k;
      make_operands(w, a_vec, b_vec);
      // the low element of the small divisors doubles as the scalar
      rand_bits(32 - w, tmp);
      tmp = (tmp << w) | (a_vec & ({VLEN{1'b1}} >> (VLEN - w)));
      issue_uop(OP_DIVU, SRC_VX, w, '0, b_vec, tmp[31:0], 0);
      issue_uop(OP_REMU, SRC_VX, w, '0, b_vec, tmp[31:0], 0);
      issue_uop(OP_DIV, SRC_VX, w, '0, b_vec, tmp[31:0], 0);
      issue_uop(OP_REM, SRC_VX, w, '0, b_vec, tmp[31:0], 0);
    end
    end_test("vx broadcast", start_errs);

    start_errs = errors;
    for (int k = 0; k < 3; k++) begin
      w = 8 << k;
      rand_bits(VLEN, b_vec);
      issue_uop(OP_DIVU, SRC_VV, w, '0, b_vec, '0, 0);
      issue_uop(OP_REMU, SRC_VV, w, '0, b_vec, '0, 0);
      issue_uop(OP_DIV, SRC_VV, w, '0, b_vec, '0, 0);
      issue_uop(OP_REM, SRC_VV, w, '0, b_vec, '0, 0);
      // most negative over minus one in every element
      b_vec = '0;
      for (int e = 0; e < VLEN / w; e++) begin
        b_vec[e * w + w - 1] = 1'b1;
      end
      issue_uop(OP_DIV, SRC_VV, w, {VLEN{1'b1}}, b_vec, '0, 0);
      issue_uop(OP_REM, SRC_VV, w, {VLEN{1'b1}}, b_vec, '0, 0);
    end
    end_test("zero divisor and overflow", start_errs);

    start_errs = errors;
    make_operands(16, a_vec, b_vec);
    issue_uop(OP_DIV, SRC_VV, 16, a_vec, b_vec, '0, 6);
    make_operands(32, a_vec, b_vec);
    issue_uop(OP_REMU, SRC_VV, 32, a_vec, b_vec, '0, 0);
    end_test("back-pressure", start_errs);

    $display("%0d tests run, %0d failed, %0d checks failed",
             tests_run, tests_failed, errors);
    if (!timed_out && errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

/* tb_clk_gen.sv */
`timescale 1ns/1ns

module tb_clk_gen #(
  parameter int PERIOD     = 8,
  parameter int RST_CYCLES = 3
) (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  // release on a falling edge like every other DUT input
  initial begin
    rst_n = 1'b0;
    repeat (RST_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
  end

endmodule

/* div_unit.sv */
`timescale 1ns/1ns

module div_unit import div_pkg::*; #(
  parameter int VLEN = 128
) (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            uop_valid,
  input  div_ctrl_t       uop_ctrl,
  input  logic [VLEN-1:0] vs1_data,
  input  logic [VLEN-1:0] vs2_data,
  input  xreg_t           rs1_data,
  input  logic            result_ready,
  output logic            result_valid,
  output rob_tag_t        result_tag,
  output logic [VLEN-1:0] result_data
);

  localparam int N8  = VLEN / 16;
  localparam int N16 = VLEN / 32;
  localparam int N32 = VLEN / 32;

  div_ctrl_t        job_ctrl;
  logic             start8;
  logic             start16;
  logic             start32;
  logic             signed_op;
  logic             retire;
  byte_t  [N8-1:0]  dividend8;
  byte_t  [N8-1:0]  divisor8;
  byte_t  [N8-1:0]  quotient8;
  byte_t  [N8-1:0]  remainder8;
  logic   [N8-1:0]  done8;
  hword_t [N16-1:0] dividend16;
  hword_t [N16-1:0] divisor16;
  hword_t [N16-1:0] quotient16;
  hword_t [N16-1:0] remainder16;
  logic   [N16-1:0] done16;
  word_t  [N32-1:0] dividend32;
  word_t  [N32-1:0] divisor32;
  word_t  [N32-1:0] quotient32;
  word_t  [N32-1:0] remainder32;
  logic   [N32-1:0] done32;

  div_operand_prep #(
    .VLEN (VLEN)
  ) u_prep (
    .clk        (clk),
    .rst_n      (rst_n),
    .uop_valid  (uop_valid),
    .uop_ctrl   (uop_ctrl),
    .vs1_data   (vs1_data),
    .vs2_data   (vs2_data),
    .rs1_data   (rs1_data),
    .retire     (retire),
    .job_ctrl   (job_ctrl),
    .start8     (start8),
    .start16    (start16),
    .start32    (start32),
    .signed_op  (signed_op),
    .dividend8  (dividend8),
    .divisor8   (divisor8),
    .dividend16 (dividend16),
    .divisor16  (divisor16),
    .dividend32 (dividend32),
    .divisor32  (divisor32)
  );

  for (genvar j = 0; j < N8; j++) begin : g_div8
    div_lane #(.DIV_WIDTH(8)) u_lane (
      .clk (clk), .rst_n (rst_n), .start (start8), .signed_op (signed_op),
      .dividend (dividend8[j]), .divisor (divisor8[j]), .ack (retire),
      .quotient (quotient8[j]), .remainder (remainder8[j]), .done (done8[j])
    );
  end

  for (genvar j = 0; j < N16; j++) begin : g_div16
    div_lane #(.DIV_WIDTH(16)) u_lane (
      .clk (clk), .rst_n (rst_n), .start (start16), .signed_op (signed_op),
      .dividend (dividend16[j]), .divisor (divisor16[j]), .ack (retire),
      .quotient (quotient16[j]), .remainder (remainder16[j]), .done (done16[j])
    );
  end

  for (genvar j = 0; j < N32; j++) begin : g_div32
    div_lane #(.DIV_WIDTH(32)) u_lane (
      .clk (clk), .rst_n (rst_n), .start (start32), .signed_op (signed_op),
      .dividend (dividend32[j]), .divisor (divisor32[j]), .ack (retire),
      .quotient (quotient32[j]), .remainder (remainder32[j]), .done (done32[j])
    );
  end

  div_result_pack #(
    .VLEN (VLEN)
  ) u_pack (
    .clk          (clk),
    .rst_n        (rst_n),
    .job_ctrl     (job_ctrl),
    .done8        (done8),
    .done16       (done16),
    .done32       (done32),
    .quotient8    (quotient8),
    .remainder8   (remainder8),
    .quotient16   (quotient16),
    .remainder16  (remainder16),
    .quotient32   (quotient32),
    .remainder32  (remainder32),
    .result_ready (result_ready),
    .result_valid (result_valid),
    .result_tag   (result_tag),
    .result_data  (result_data),
    .retire       (retire)
  );

endmodule

/* div_result_pack.sv */
`timescale 1ns/1ns

module div_result_pack import div_pkg::*; #(
  parameter int VLEN = 128
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  div_ctrl_t            job_ctrl,
  input  logic   [VLEN/16-1:0] done8,
  input  logic   [VLEN/32-1:0] done16,
  input  logic   [VLEN/32-1:0] done32,
  input  byte_t  [VLEN/16-1:0] quotient8,
  input  byte_t  [VLEN/16-1:0] remainder8,
  input  hword_t [VLEN/32-1:0] quotient16,
  input  hword_t [VLEN/32-1:0] remainder16,
  input  word_t  [VLEN/32-1:0] quotient32,
  input  word_t  [VLEN/32-1:0] remainder32,
  input  logic                 result_ready,
  output logic                 result_valid,
  output rob_tag_t             result_tag,
  output logic   [VLEN-1:0]    result_data,
  output logic                 retire
);

  localparam int N8  = VLEN / 16;
  localparam int N16 = VLEN / 32;
  localparam int N32 = VLEN / 32;

  logic                 all_done;
  logic                 use_rem;
  byte_t  [N8-1:0]      sel8;
  hword_t [N16-1:0]     sel16;
  word_t  [N32-1:0]     sel32;

  // only lanes of the groups in use count
  always_comb begin
    case (job_ctrl.eew)
      EEW8:    all_done = &{done8, done16, done32};
      EEW16:   all_done = &{done16, done32};
      default: all_done = &done32;
    endcase
  end

  // cleared on the retire edge along with the lane done flags
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      result_valid <= 1'b0;
    end else if (retire) begin
      result_valid <= 1'b0;
    end else begin
      result_valid <= all_done;
    end
  end

  assign retire     = result_valid & result_ready;
  assign result_tag = job_ctrl.tag;
  assign use_rem    = (job_ctrl.op == OP_REMU) || (job_ctrl.op == OP_REM);

  always_comb begin
    for (int i = 0; i < N8; i++) begin
      sel8[i] = use_rem ? remainder8[i] : quotient8[i];
    end
    for (int i = 0; i < N16; i++) begin
      sel16[i] = use_rem ? remainder16[i] : quotient16[i];
    end
    for (int i = 0; i < N32; i++) begin
      sel32[i] = use_rem ? remainder32[i] : quotient32[i];
    end
  end

  // back into element order from the low eew bits of each lane
  always_comb begin
    result_data = '0;
    case (job_ctrl.eew)
      EEW8: begin
        for (int i = 0; i < N8; i++) begin
          result_data[i*8 +: 8] = sel8[i];
        end
        for (int i = 0; i < N16; i++) begin
          result_data[(N8+i)*8 +: 8] = sel16[i][7:0];
        end
        for (int i = 0; i < N32; i++) begin
          result_data[(N8+N16+i)*8 +: 8] = sel32[i][7:0];
        end
      end
      EEW16: begin
        for (int i = 0; i < N16; i++) begin
          result_data[i*16 +: 16] = sel16[i];
        end
        for (int i = 0; i < N32; i++) begin
          result_data[(N16+i)*16 +: 16] = sel32[i][15:0];
        end
      end
      default: begin
        for (int i = 0; i < N32; i++) begin
          result_data[i*32 +: 32] = sel32[i];
        end
      end
    endcase
  end

endmodule

/* div_operand_prep.sv */
`timescale 1ns/1ns

module div_operand_prep import div_pkg::*; #(
  parameter int VLEN = 128
) (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       uop_valid,
  input  div_ctrl_t                  uop_ctrl,
  input  logic [VLEN-1:0]            vs1_data,
  input  logic [VLEN-1:0]            vs2_data,
  input  xreg_t                      rs1_data,
  input  logic                       retire,
  output div_ctrl_t                  job_ctrl,
  output logic                       start8,
  output logic                       start16,
  output logic                       start32,
  output logic                       signed_op,
  output byte_t  [VLEN/16-1:0]       dividend8,
  output byte_t  [VLEN/16-1:0]       divisor8,
  output hword_t [VLEN/32-1:0]       dividend16,
  output hword_t [VLEN/32-1:0]       divisor16,
  output word_t  [VLEN/32-1:0]       dividend32,
  output word_t  [VLEN/32-1:0]       divisor32
);

  localparam int N8  = VLEN / 16;
  localparam int N16 = VLEN / 32;
  localparam int N32 = VLEN / 32;

  prep_state_e     state;
  logic            capture;
  logic            vx;
  logic [VLEN-1:0] vs1_q;
  logic [VLEN-1:0] vs2_q;
  xreg_t           rs1_q;

  // picks one element (or the scalar) and extends it to 32 bits
  function automatic word_t lane_operand(input logic [VLEN-1:0] vec,
                                         input int unsigned     idx,
                                         input eew_e            eew,
                                         input logic            use_scalar,
                                         input xreg_t           scalar,
                                         input logic            sgn);
    word_t raw;
    word_t ext;
    if (use_scalar) begin
      raw = scalar;
    end else begin
      case (eew)
        EEW8:    raw = {24'b0, vec[idx*8 +: 8]};
        EEW16:   raw = {16'b0, vec[idx*16 +: 16]};
        default: raw = vec[idx*32 +: 32];
      endcase
    end
    case (eew)
      EEW8:    ext = {{24{sgn & raw[7]}}, raw[7:0]};
      EEW16:   ext = {{16{sgn & raw[15]}}, raw[15:0]};
      default: ext = raw;
    endcase
    return ext;
  endfunction

  assign capture   = (state == ST_IDLE) && uop_valid;
  assign vx        = (job_ctrl.src_sel == SRC_VX);
  assign signed_op = (job_ctrl.op == OP_DIV) || (job_ctrl.op == OP_REM);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state    <= ST_IDLE;
      job_ctrl <= '0;
      start8   <= 1'b0;
      start16  <= 1'b0;
      start32  <= 1'b0;
    end else begin
      // only the groups that this element width maps onto
      start8  <= capture && (uop_ctrl.eew == EEW8);
      start16 <= capture && ((uop_ctrl.eew == EEW8) || (uop_ctrl.eew == EEW16));
      start32 <= capture;
      if (capture) begin
        state    <= ST_BUSY;
        job_ctrl <= uop_ctrl;
      end else if (retire) begin
        state <= ST_IDLE;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (capture) begin
      vs1_q <= vs1_data;
      vs2_q <= vs2_data;
      rs1_q <= rs1_data;
    end
  end

  always_comb begin
    int unsigned base16;
    int unsigned base32;
    eew_e        eew16;
    eew16 = (job_ctrl.eew == EEW8) ? EEW8 : EEW16;
    case (job_ctrl.eew)
      EEW8: begin
        base16 = N8;
        base32 = N8 + N16;
      end
      EEW16: begin
        base16 = 0;
        base32 = N16;
      end
      default: begin
        base16 = 0;
        base32 = 0;
      end
    endcase
    // 8-bit lanes only serve the low half at eew 8
    for (int i = 0; i < N8; i++) begin
      dividend8[i] = byte_t'(lane_operand(vs2_q, i, EEW8, 1'b0, rs1_q, signed_op));
      divisor8[i]  = byte_t'(lane_operand(vs1_q, i, EEW8, vx, rs1_q, signed_op));
    end
    for (int i = 0; i < N16; i++) begin
      dividend16[i] = hword_t'(lane_operand(vs2_q, base16 + i, eew16, 1'b0, rs1_q, signed_op));
      divisor16[i]  = hword_t'(lane_operand(vs1_q, base16 + i, eew16, vx, rs1_q, signed_op));
    end
    for (int i = 0; i < N32; i++) begin
      dividend32[i] = lane_operand(vs2_q, base32 + i, job_ctrl.eew, 1'b0, rs1_q, signed_op);
      divisor32[i]  = lane_operand(vs1_q, base32 + i, job_ctrl.eew, vx, rs1_q, signed_op);
    end
  end

endmodule

/* div_lane.sv */
`timescale 1ns/1ns

module div_lane #(
  parameter int DIV_WIDTH = 8
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 start,
  input  logic                 signed_op,
  input  logic [DIV_WIDTH-1:0] dividend,
  input  logic [DIV_WIDTH-1:0] divisor,
  input  logic                 ack,
  output logic [DIV_WIDTH-1:0] quotient,
  output logic [DIV_WIDTH-1:0] remainder,
  output logic                 done
);

  localparam int CNT_W = $clog2(DIV_WIDTH + 1);

  logic                 busy;
  logic [CNT_W-1:0]     cnt;
  logic                 last;
  logic [DIV_WIDTH-1:0] q_reg;
  logic [DIV_WIDTH-1:0] r_reg;
  logic [DIV_WIDTH-1:0] d_reg;
  logic                 q_neg;
  logic                 r_neg;
  logic                 a_neg;
  logic                 b_neg;
  logic [DIV_WIDTH-1:0] a_mag;
  logic [DIV_WIDTH-1:0] b_mag;
  logic [DIV_WIDTH:0]   r_shift;
  logic [DIV_WIDTH+1:0] diff;

  assign a_neg = signed_op & dividend[DIV_WIDTH-1];
  assign b_neg = signed_op & divisor[DIV_WIDTH-1];
  // magnitude of the most negative value still fits unsigned
  assign a_mag = a_neg ? -dividend : dividend;
  assign b_mag = b_neg ? -divisor : divisor;

  // one restoring step
  assign r_shift = {r_reg, q_reg[DIV_WIDTH-1]};
  assign diff    = {1'b0, r_shift} - {2'b0, d_reg};
  assign last    = (cnt == CNT_W'(DIV_WIDTH));

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      busy <= 1'b0;
      done <= 1'b0;
      cnt  <= '0;
    end else begin
      if (start) begin
        busy <= 1'b1;
        done <= 1'b0;
        cnt  <= '0;
      end else if (busy) begin
        if (last) begin
          busy <= 1'b0;
          done <= 1'b1;
        end else begin
          cnt <= cnt + 1'b1;
        end
      end else if (ack) begin
        done <= 1'b0;
      end
    end
  end

  // divide by zero runs the same steps and leaves all ones in the quotient
  // and the dividend magnitude in the remainder
  // overflow wraps the positive quotient back to the dividend
  always_ff @(posedge clk) begin
    if (start) begin
      q_reg <= a_mag;
      r_reg <= '0;
      d_reg <= b_mag;
      q_neg <= (a_neg ^ b_neg) & (divisor != '0);
      r_neg <= a_neg;
    end else if (busy && !last) begin
      if (diff[DIV_WIDTH+1]) begin
        r_reg <= r_shift[DIV_WIDTH-1:0];
        q_reg <= {q_reg[DIV_WIDTH-2:0], 1'b0};
      end else begin
        r_reg <= diff[DIV_WIDTH-1:0];
        q_reg <= {q_reg[DIV_WIDTH-2:0], 1'b1};
      end
    end else if (busy) begin
      // sign fix-up in the final cycle
      q_reg <= q_neg ? -q_reg : q_reg;
      r_reg <= r_neg ? -r_reg : r_reg;
    end
  end

  assign quotient  = q_reg;
  assign remainder = r_reg;

endmodule

/* div_pkg.sv */
package div_pkg;

  // element widths carried by the lanes
  typedef logic [7:0]  byte_t;
  typedef logic [15:0] hword_t;
  typedef logic [31:0] word_t;

  // scalar operand from the integer register file
  typedef logic [31:0] xreg_t;

  localparam int ROB_TAG_W = 4;

  typedef logic [ROB_TAG_W-1:0] rob_tag_t;

  typedef enum logic [1:0] {
    EEW8  = 2'd0,
    EEW16 = 2'd1,
    EEW32 = 2'd2
  } eew_e;

  typedef enum logic [1:0] {
    OP_DIVU = 2'd0,
    OP_DIV  = 2'd1,
    OP_REMU = 2'd2,
    OP_REM  = 2'd3
  } div_op_e;

  typedef enum logic {
    SRC_VV = 1'b0,
    SRC_VX = 1'b1
  } src_sel_e;

  // fixed-width control fields of one micro-op
  typedef struct packed {
    rob_tag_t tag;
    div_op_e  op;
    src_sel_e src_sel;
    eew_e     eew;
  } div_ctrl_t;

  typedef enum logic {
    ST_IDLE = 1'b0,
    ST_BUSY = 1'b1
  } prep_state_e;

endpackage
